/* verilog/debug_pkg.sv */
package debug_pkg;

    // Serial link and core sizes
    localparam int NB_DATA      = 8;
    localparam int NB_WORD      = 32;
    localparam int CLKS_PER_BIT = 4;    // Short bit time for simulation

    localparam int IM_BYTES   = 64;
    localparam int RB_DEPTH   = 8;
    localparam int DM_DEPTH   = 8;
    localparam int NB_RB_ADDR = 3;
    localparam int NB_DM_ADDR = 3;
    localparam int NB_IM_ADDR = 6;      // Byte address into instruction memory

    // Command bytes from the host
    typedef enum logic [NB_DATA-1:0] {
        CMD_WRITE_IM  = 8'd1,
        CMD_RUN       = 8'd2,
        CMD_STEP_MODE = 8'd3,
        CMD_SEND_RB   = 8'd4,
        CMD_SEND_DM   = 8'd5,
        CMD_SEND_PC   = 8'd6,
        CMD_STEP      = 8'd7,
        CMD_CONTINUE  = 8'd8
    } debug_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_IM,
        ST_READY,
        ST_RUN,
        ST_STEP_MODE,
        ST_SEND_PC,
        ST_SEND_DM,
        ST_SEND_RB
    } debug_state_e;

    // Top byte of each instruction, unknown values act as NOP
    typedef enum logic [NB_DATA-1:0] {
        OP_NOP  = 8'd0,
        OP_ADDI = 8'd1,
        OP_ADD  = 8'd2,
        OP_SW   = 8'd3,
        OP_LW   = 8'd4,
        OP_HALT = 8'd255
    } opcode_e;

endpackage

/* verilog/uart_rx.sv */
module uart_rx (
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_rx,
    output logic [debug_pkg::NB_DATA-1:0] o_rx_data,
    output logic                          o_rx_done
);
    import debug_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e                       state;
    logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
    logic [2:0]                      bit_cnt;
    logic                            rx_prev;   // Previous line sample for edge detect
    logic                            bit_tick;

    // One full bit period after the previous sample point
    assign bit_tick = (clk_cnt == CLKS_PER_BIT - 1);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            rx_prev   <= 1'b1;
            o_rx_done <= 1'b0;
        end else begin
            rx_prev   <= i_rx;
            o_rx_done <= 1'b0;
            clk_cnt   <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !i_rx)
                        state <= RX_START;
                end
                RX_START: begin
                    if (clk_cnt == CLKS_PER_BIT / 2 - 1) begin   // Middle of start bit
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        if (i_rx)
                            state <= RX_IDLE;   // Glitch, not a real start
                        else
                            state <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(NB_DATA - 1))
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        o_rx_done <= i_rx;      // Low stop bit drops the byte
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge i_clock) begin
        if (state == RX_DATA && bit_tick)
            o_rx_data <= {i_rx, o_rx_data[NB_DATA-1:1]};
    end

endmodule

/* verilog/uart_tx.sv */
module uart_tx (
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_tx_start,
    input  logic [debug_pkg::NB_DATA-1:0] i_tx_data,
    output logic                          o_tx,
    output logic                          o_tx_done
);
    import debug_pkg::*;

    logic                            busy;
    logic                            bit_tick;
    logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
    logic [3:0]                      bit_idx;   // 0 is start bit, 9 is stop bit
    logic [NB_DATA:0]                shreg;     // Data bits with the stop bit on top

    assign bit_tick = busy && (clk_cnt == CLKS_PER_BIT - 1);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy      <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            o_tx      <= 1'b1;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (!busy) begin
                if (i_tx_start) begin   // Start while busy is ignored
                    busy    <= 1'b1;
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    o_tx    <= 1'b0;
                end
            end else if (bit_tick) begin
                clk_cnt <= '0;
                if (bit_idx == 4'd9) begin
                    // End of stop bit
                    busy      <= 1'b0;
                    o_tx      <= 1'b1;
                    o_tx_done <= 1'b1;
                end else begin
                    o_tx    <= shreg[0];
                    bit_idx <= bit_idx + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (!busy && i_tx_start)
            shreg <= {1'b1, i_tx_data};
        else if (bit_tick)
            shreg <= shreg >> 1;
    end

endmodule

/* verilog/debug_unit.sv */
module debug_unit (
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic                             i_rx_done,
    input  logic [debug_pkg::NB_DATA-1:0]    i_rx_data,
    input  logic                             i_tx_done,
    input  logic                             i_halted,
    input  logic [debug_pkg::NB_WORD-1:0]    i_pc,
    input  logic [debug_pkg::NB_WORD-1:0]    i_rb_data,
    input  logic [debug_pkg::NB_WORD-1:0]    i_dm_data,
    output logic                             o_tx_start,
    output logic [debug_pkg::NB_DATA-1:0]    o_tx_data,
    output logic                             o_run,
    output logic                             o_step,
    output logic                             o_clear,
    output logic                             o_im_write,
    output logic [debug_pkg::NB_IM_ADDR-1:0] o_im_addr,
    output logic [debug_pkg::NB_DATA-1:0]    o_im_data,
    output logic [debug_pkg::NB_RB_ADDR-1:0] o_rb_addr,
    output logic [debug_pkg::NB_DM_ADDR-1:0] o_dm_addr,
    output debug_pkg::debug_state_e          o_state
);
    import debug_pkg::*;

    debug_state_e          state;
    debug_state_e          dump_next;   // Where the current dump goes when finished
    debug_cmd_e            rx_cmd;
    logic                  from_step;   // Dump chain started by a step
    logic                  sending;     // Byte handed to the transmitter
    logic                  dumping;
    logic                  tx_go;
    logic                  last_word;
    logic [1:0]            byte_cnt;
    logic [NB_RB_ADDR-1:0] word_cnt;    // Shared by the DM and RB dumps
    logic [NB_IM_ADDR-1:0] im_cnt;
    logic [NB_WORD-1:0]    dump_word;
    logic [NB_DATA-1:0]    dump_byte;

    assign rx_cmd  = debug_cmd_e'(i_rx_data);
    assign dumping = state inside {ST_SEND_PC, ST_SEND_DM, ST_SEND_RB};
    // Hold off one cycle after a step so the dump sees the new PC
    assign tx_go   = dumping && !sending && !o_step;

    assign o_run     = (state == ST_RUN);
    assign o_rb_addr = word_cnt;
    assign o_dm_addr = word_cnt;
    assign o_state   = state;

    always_comb begin
        dump_word = i_rb_data;
        last_word = (word_cnt == NB_RB_ADDR'(RB_DEPTH - 1));
        if (from_step && !i_halted)
            dump_next = ST_STEP_MODE;
        else
            dump_next = ST_IDLE;
        case (state)
            ST_SEND_PC: begin
                dump_word = i_pc;
                last_word = 1'b1;
                dump_next = from_step ? ST_SEND_DM : ST_IDLE;
            end
            ST_SEND_DM: begin
                dump_word = i_dm_data;
                last_word = (word_cnt == NB_RB_ADDR'(DM_DEPTH - 1));
                dump_next = from_step ? ST_SEND_RB : ST_IDLE;
            end
            default: ;
        endcase
        // Most significant byte goes out first
        dump_byte = dump_word[(3 - byte_cnt) * NB_DATA +: NB_DATA];
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= ST_IDLE;
            from_step  <= 1'b0;
            sending    <= 1'b0;
            byte_cnt   <= '0;
            word_cnt   <= '0;
            im_cnt     <= '0;
            o_tx_start <= 1'b0;
            o_step     <= 1'b0;
            o_clear    <= 1'b0;
            o_im_write <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            o_step     <= 1'b0;
            o_clear    <= 1'b0;
            o_im_write <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_rx_done) begin
                        from_step <= 1'b0;
                        case (rx_cmd)
                            CMD_WRITE_IM: begin
                                o_clear <= 1'b1;    // Fresh core for the new program
                                im_cnt  <= '0;
                                state   <= ST_LOAD_IM;
                            end
                            CMD_SEND_PC: state <= ST_SEND_PC;
                            CMD_SEND_DM: state <= ST_SEND_DM;
                            CMD_SEND_RB: state <= ST_SEND_RB;
                            default: ;
                        endcase
                    end
                end
                ST_LOAD_IM: begin
                    if (i_rx_done) begin
                        o_im_write <= 1'b1;
                        im_cnt     <= im_cnt + 1'b1;
                        if (im_cnt == NB_IM_ADDR'(IM_BYTES - 1))
                            state <= ST_READY;
                    end
                end
                ST_READY: begin
                    if (i_rx_done && rx_cmd == CMD_RUN)
                        state <= ST_RUN;
                    else if (i_rx_done && rx_cmd == CMD_STEP_MODE)
                        state <= ST_STEP_MODE;
                end
                ST_RUN: begin
                    if (i_halted)
                        state <= ST_IDLE;
                end
                ST_STEP_MODE: begin
                    if (i_rx_done && rx_cmd == CMD_STEP) begin
                        o_step    <= 1'b1;
                        from_step <= 1'b1;
                        state     <= ST_SEND_PC;
                    end else if (i_rx_done && rx_cmd == CMD_CONTINUE) begin
                        state <= ST_RUN;
                    end
                end
                default: begin
                    // PC, DM and RB dumps, one byte per transmitter frame
                    if (tx_go) begin
                        o_tx_start <= 1'b1;
                        sending    <= 1'b1;
                    end else if (sending && i_tx_done) begin
                        sending  <= 1'b0;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            word_cnt <= word_cnt + 1'b1;
                            if (last_word) begin
                                word_cnt <= '0;
                                state    <= dump_next;
                            end
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == ST_LOAD_IM && i_rx_done) begin
            o_im_addr <= im_cnt;
            o_im_data <= i_rx_data;
        end
        if (tx_go)
            o_tx_data <= dump_byte;
    end

endmodule

/* verilog/toy_core.sv */
module toy_core (
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic                             i_clear,
    input  logic                             i_run,
    input  logic                             i_step,
    input  logic                             i_im_write,
    input  logic [debug_pkg::NB_IM_ADDR-1:0] i_im_addr,
    input  logic [debug_pkg::NB_DATA-1:0]    i_im_data,
    input  logic [debug_pkg::NB_RB_ADDR-1:0] i_rb_addr,
    input  logic [debug_pkg::NB_DM_ADDR-1:0] i_dm_addr,
    output logic [debug_pkg::NB_WORD-1:0]    o_pc,
    output logic [debug_pkg::NB_WORD-1:0]    o_rb_data,
    output logic [debug_pkg::NB_WORD-1:0]    o_dm_data,
    output logic                             o_halted
);
    import debug_pkg::*;

    logic [NB_DATA-1:0]    im [IM_BYTES];
    logic [NB_WORD-1:0]    rb [RB_DEPTH];
    logic [NB_WORD-1:0]    dm [DM_DEPTH];
    logic [NB_WORD-1:0]    pc;
    logic                  halted;
    logic                  exec;
    logic [NB_IM_ADDR-3:0] base;        // Word index of the current instruction
    logic [NB_WORD-1:0]    instr;
    opcode_e               opcode;
    logic [NB_RB_ADDR-1:0] rd;
    logic [NB_RB_ADDR-1:0] rs;
    logic [NB_DATA-1:0]    imm;

    // Big-endian fetch of opcode, rd, rs, imm
    assign base   = pc[NB_IM_ADDR-1:2];
    assign instr  = {im[{base, 2'd0}], im[{base, 2'd1}], im[{base, 2'd2}], im[{base, 2'd3}]};
    assign opcode = opcode_e'(instr[31:24]);
    assign rd     = instr[16 +: NB_RB_ADDR];
    assign rs     = instr[8 +: NB_RB_ADDR];
    assign imm    = instr[7:0];

    assign exec = (i_run || i_step) && !halted;

    always_ff @(posedge i_clock) begin
        if (i_im_write)
            im[i_im_addr] <= i_im_data;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_clear) begin
            pc     <= '0;
            halted <= 1'b0;
            for (int i = 0; i < RB_DEPTH; i++)
                rb[i] <= '0;
            for (int i = 0; i < DM_DEPTH; i++)
                dm[i] <= '0;
        end else if (exec) begin
            // PC stays on the HALT instruction
            if (opcode != OP_HALT)
                pc <= pc + NB_WORD'(4);
            case (opcode)
                OP_ADDI: rb[rd] <= rb[rs] + NB_WORD'(imm);
                OP_ADD:  rb[rd] <= rb[rs] + rb[imm[NB_RB_ADDR-1:0]];
                OP_SW:   dm[imm[NB_DM_ADDR-1:0]] <= rb[rs];
                OP_LW:   rb[rd] <= dm[imm[NB_DM_ADDR-1:0]];
                OP_HALT: halted <= 1'b1;
                default: ;  // NOP and unknown opcodes
            endcase
        end
    end

    // Debug read ports
    assign o_pc      = pc;
    assign o_rb_data = rb[i_rb_addr];
    assign o_dm_data = dm[i_dm_addr];
    assign o_halted  = halted;

endmodule

/* verilog/debug_top.sv */
module debug_top (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_rx,
    output logic                    o_tx,
    output logic                    o_halted,
    output debug_pkg::debug_state_e o_state
);
    import debug_pkg::*;

    // UART side
    logic [NB_DATA-1:0]    rx_data;
    logic                  rx_done;
    logic [NB_DATA-1:0]    tx_data;
    logic                  tx_start;
    logic                  tx_done;

    // Core control and debug reads
    logic                  run;
    logic                  step;
    logic                  clear;
    logic                  im_write;
    logic [NB_IM_ADDR-1:0] im_addr;
    logic [NB_DATA-1:0]    im_data;
    logic [NB_RB_ADDR-1:0] rb_addr;
    logic [NB_DM_ADDR-1:0] dm_addr;
    logic [NB_WORD-1:0]    pc;
    logic [NB_WORD-1:0]    rb_data;
    logic [NB_WORD-1:0]    dm_data;

    uart_rx uart_rx_inst (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rx      (i_rx),
        .o_rx_data (rx_data),
        .o_rx_done (rx_done)
    );

    uart_tx uart_tx_inst (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_tx       (o_tx),
        .o_tx_done  (tx_done)
    );

    debug_unit debug_unit_inst (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx_done  (rx_done),
        .i_rx_data  (rx_data),
        .i_tx_done  (tx_done),
        .i_halted   (o_halted),
        .i_pc       (pc),
        .i_rb_data  (rb_data),
        .i_dm_data  (dm_data),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data),
        .o_run      (run),
        .o_step     (step),
        .o_clear    (clear),
        .o_im_write (im_write),
        .o_im_addr  (im_addr),
        .o_im_data  (im_data),
        .o_rb_addr  (rb_addr),
        .o_dm_addr  (dm_addr),
        .o_state    (o_state)
    );

    toy_core toy_core_inst (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_clear    (clear),
        .i_run      (run),
        .i_step     (step),
        .i_im_write (im_write),
        .i_im_addr  (im_addr),
        .i_im_data  (im_data),
        .i_rb_addr  (rb_addr),
        .i_dm_addr  (dm_addr),
        .o_pc       (pc),
        .o_rb_data  (rb_data),
        .o_dm_data  (dm_data),
        .o_halted   (o_halted)
    );

endmodule

/* tests/tb_clock.sv */
module tb_clock (
    output logic o_clock
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam real HALF_PERIOD = 10.0;   // 20 ns period

    initial begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD) o_clock = ~o_clock;
    end

endmodule

/* tests/debug_tb.sv */
module debug_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import debug_pkg::*;

    localparam int NUM_ROWS     = 4;
    localparam int PROG_WORDS   = IM_BYTES / 4;
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    localparam int STEP_BYTES   = 4 + 4 * DM_DEPTH + 4 * RB_DEPTH;

    logic         clock;
    logic         reset;
    logic         rx;
    logic         tx;
    logic         halted;
    debug_state_e state;

    // Test table, one row per program
    string              row_name  [NUM_ROWS];
    logic [NB_WORD-1:0] row_prog  [NUM_ROWS][PROG_WORDS];
    int                 row_steps [NUM_ROWS];   // Zero means plain run
    logic [NB_WORD-1:0] row_pc    [NUM_ROWS];
    logic [NB_WORD-1:0] row_rb    [NUM_ROWS][RB_DEPTH];
    logic [NB_WORD-1:0] row_dm    [NUM_ROWS][DM_DEPTH];

    // Reference model of the instruction set
    logic [NB_WORD-1:0] model_pc;
    logic [NB_WORD-1:0] model_rb [RB_DEPTH];
    logic [NB_WORD-1:0] model_dm [DM_DEPTH];
    logic               model_halted;

    logic [NB_DATA-1:0] rx_bytes[$];    // Bytes decoded from o_tx
    int value_errors = 0;
    int other_errors = 0;
    int cycles = 0;
    int cycle_limit = 0;
    int seed;

    tb_clock tb_clock_inst (.o_clock(clock));

    debug_top debug_top_inst (
        .i_clock  (clock),
        .i_reset  (reset),
        .i_rx     (rx),
        .o_tx     (tx),
        .o_halted (halted),
        .o_state  (state)
    );

    function automatic logic [NB_WORD-1:0] encode(int op, int rd, int rs, int imm);
        return {8'(op), 8'(rd), 8'(rs), 8'(imm)};
    endfunction

    task automatic check_byte(input string label, input logic [NB_DATA-1:0] expected,
                              input logic [NB_DATA-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", label, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_word(input string label, input logic [NB_WORD-1:0] expected,
                              input logic [NB_WORD-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", label, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_state(input string label, input debug_state_e expected,
                               input debug_state_e actual);
        if (actual !== expected) begin
            $display("error %s: expected %s, actual %s", label, expected.name(), actual.name());
            value_errors++;
        end
    endtask

    task automatic check_flag(input string label, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, actual %b", label, expected, actual);
            value_errors++;
        end
    endtask

    task automatic clear_model();
        model_pc     = '0;
        model_halted = 1'b0;
        for (int i = 0; i < RB_DEPTH; i++)
            model_rb[i] = '0;
        for (int i = 0; i < DM_DEPTH; i++)
            model_dm[i] = '0;
    endtask

    // One instruction of the given row's program
    task automatic exec_model(input int row);
        logic [NB_WORD-1:0] instr;
        logic [2:0]         rd;
        logic [2:0]         rs;
        logic [7:0]         imm;
        instr = row_prog[row][model_pc[NB_IM_ADDR-1:2]];
        rd    = instr[18:16];
        rs    = instr[10:8];
        imm   = instr[7:0];
        if (!model_halted) begin
            case (instr[31:24])
                OP_ADDI: model_rb[rd] = model_rb[rs] + {24'd0, imm};
                OP_ADD:  model_rb[rd] = model_rb[rs] + model_rb[imm[2:0]];
                OP_SW:   model_dm[imm[2:0]] = model_rb[rs];
                OP_LW:   model_rb[rd] = model_dm[imm[2:0]];
                OP_HALT: model_halted = 1'b1;
                default: ;
            endcase
            if (instr[31:24] != OP_HALT)
                model_pc = model_pc + 32'd4;
        end
    endtask

    task automatic build_table();
        int total;
        int r0;
        int r1;
        int r2;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int w = 0; w < PROG_WORDS; w++)
                row_prog[r][w] = '0;   // NOP padding
        end

        row_name[0]  = "run_basic";
        row_steps[0] = 0;
        row_prog[0][0] = encode(OP_ADDI, 1, 0, 5);
        row_prog[0][1] = encode(OP_ADDI, 2, 1, 10);
        row_prog[0][2] = encode(OP_ADD, 3, 1, 2);
        row_prog[0][3] = encode(OP_SW, 0, 3, 3);
        row_prog[0][4] = encode(OP_LW, 4, 0, 3);
        row_prog[0][5] = encode(OP_ADD, 5, 4, 4);
        row_prog[0][6] = encode(OP_SW, 0, 5, 7);
        row_prog[0][7] = encode(OP_HALT, 0, 0, 0);
        row_pc[0] = 32'd28;
        row_rb[0] = '{32'd0, 32'd5, 32'd15, 32'd20, 32'd20, 32'd40, 32'd0, 32'd0};
        row_dm[0] = '{32'd0, 32'd0, 32'd0, 32'd20, 32'd0, 32'd0, 32'd0, 32'd40};

        row_name[1]  = "step_continue";
        row_steps[1] = 4;
        row_prog[1][0] = encode(OP_ADDI, 7, 0, 8'hff);
        row_prog[1][1] = encode(OP_ADDI, 7, 7, 8'hff);
        row_prog[1][2] = encode(OP_SW, 0, 7, 0);
        row_prog[1][3] = encode(8'h99, 1, 1, 1);    // Unknown opcode, no effect
        row_prog[1][4] = encode(OP_ADD, 6, 7, 7);
        row_prog[1][5] = encode(OP_SW, 0, 6, 5);
        row_prog[1][6] = encode(OP_LW, 1, 0, 0);
        row_prog[1][7] = encode(OP_ADDI, 2, 1, 8'h80);
        row_prog[1][8] = encode(OP_HALT, 0, 0, 0);
        row_pc[1] = 32'd32;
        row_rb[1] = '{32'd0, 32'd510, 32'd638, 32'd0, 32'd0, 32'd0, 32'd1020, 32'd510};
        row_dm[1] = '{32'd510, 32'd0, 32'd0, 32'd0, 32'd0, 32'd1020, 32'd0, 32'd0};

        // Random immediates, results come from the model
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        row_name[2]  = "random_imm";
        row_steps[2] = 2;
        row_prog[2][0] = encode(OP_ADDI, 1, 0, r0);
        row_prog[2][1] = encode(OP_ADDI, 2, 1, r1);
        row_prog[2][2] = encode(OP_ADD, 3, 1, 2);
        row_prog[2][3] = encode(OP_SW, 0, 3, 1);
        row_prog[2][4] = encode(OP_ADDI, 4, 3, r2);
        row_prog[2][5] = encode(OP_SW, 0, 4, 6);
        row_prog[2][6] = encode(OP_LW, 5, 0, 1);
        row_prog[2][7] = encode(OP_HALT, 0, 0, 0);
        clear_model();
        for (int i = 0; i < PROG_WORDS; i++)
            exec_model(2);
        row_pc[2] = model_pc;
        row_rb[2] = model_rb;
        row_dm[2] = model_dm;

        // Reload after a halt, the core must start from zero
        row_name[3]  = "reload_clear";
        row_steps[3] = 1;
        row_prog[3][1] = encode(OP_HALT, 0, 0, 0);
        row_pc[3] = 32'd4;
        row_rb[3] = '{default: '0};
        row_dm[3] = '{default: '0};

        total = 3 + 4 + 4 * RB_DEPTH;   // Reset checks, sent and received
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += 1 + IM_BYTES + 3 + ((row_steps[r] > 0) ? 2 + row_steps[r] : 1);
            total += row_steps[r] * STEP_BYTES + 4 * RB_DEPTH + 4 * DM_DEPTH + 4;
        end
        cycle_limit = total * 12 * CLKS_PER_BIT + 2000;
    endtask

    // 8N1, LSB first, plus one idle bit
    task automatic send_byte(input logic [NB_DATA-1:0] data);
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clock);
        for (int b = 0; b < NB_DATA; b++) begin
            rx = data[b];
            repeat (CLKS_PER_BIT) @(negedge clock);
        end
        rx = 1'b1;
        repeat (2 * CLKS_PER_BIT) @(negedge clock);
    endtask

    task automatic capture_tx();
        logic [NB_DATA-1:0] data;
        forever begin
            @(negedge clock);
            if (!reset && tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clock);   // Middle of start bit
                for (int b = 0; b < NB_DATA; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge clock);
                    data[b] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clock);
                if (tx === 1'b1) begin
                    rx_bytes.push_back(data);
                end else begin
                    $display("Framing problem: a stop bit on o_tx was low");
                    other_errors++;
                end
            end
        end
    endtask

    task automatic take_byte(output logic [NB_DATA-1:0] value);
        while (rx_bytes.size() == 0)
            @(negedge clock);
        value = rx_bytes.pop_front();
    endtask

    task automatic expect_byte(input string label, input logic [NB_DATA-1:0] expected);
        logic [NB_DATA-1:0] actual;
        take_byte(actual);
        check_byte(label, expected, actual);
    endtask

    // Four bytes, most significant first
    task automatic expect_word(input string label, input logic [NB_WORD-1:0] expected);
        logic [NB_WORD-1:0] actual;
        logic [NB_DATA-1:0] b;
        actual = '0;
        for (int j = 0; j < 4; j++) begin
            take_byte(b);
            actual = {actual[NB_WORD-NB_DATA-1:0], b};
        end
        check_word(label, expected, actual);
    endtask

    task automatic wait_state(input debug_state_e target);
        while (state != target)
            @(negedge clock);
    endtask

    task automatic load_program(input int row);
        send_byte(CMD_WRITE_IM);
        for (int w = 0; w < PROG_WORDS; w++) begin
            for (int j = 0; j < 4; j++)
                send_byte(row_prog[row][w][(3 - j) * NB_DATA +: NB_DATA]);
        end
    endtask

    task automatic run_row(input int row);
        string name;
        name = row_name[row];
        load_program(row);
        wait_state(ST_READY);
        check_flag({name, " halted after load"}, 1'b0, halted);
        clear_model();
        if (row_steps[row] > 0) begin
            send_byte(CMD_STEP_MODE);
            wait_state(ST_STEP_MODE);
            for (int k = 1; k <= row_steps[row]; k++) begin
                send_byte(CMD_STEP);
                exec_model(row);
                expect_word($sformatf("%s step %0d pc", name, k), NB_WORD'(4 * k));
                for (int i = 0; i < DM_DEPTH; i++)
                    expect_word($sformatf("%s step %0d dm[%0d]", name, k, i), model_dm[i]);
                for (int i = 0; i < RB_DEPTH; i++)
                    expect_word($sformatf("%s step %0d rb[%0d]", name, k, i), model_rb[i]);
                wait_state(ST_STEP_MODE);
            end
            send_byte(CMD_CONTINUE);
        end else begin
            send_byte(CMD_RUN);
        end
        wait_state(ST_IDLE);
        check_flag({name, " halted after run"}, 1'b1, halted);

        send_byte(CMD_SEND_RB);
        for (int i = 0; i < RB_DEPTH; i++)
            expect_word($sformatf("%s rb[%0d]", name, i), row_rb[row][i]);
        wait_state(ST_IDLE);
        send_byte(CMD_SEND_DM);
        for (int i = 0; i < DM_DEPTH; i++)
            expect_word($sformatf("%s dm[%0d]", name, i), row_dm[row][i]);
        wait_state(ST_IDLE);
        send_byte(CMD_SEND_PC);
        check_state({name, " pc dump state"}, ST_SEND_PC, state);   // Dump still in progress
        expect_word({name, " pc"}, row_pc[row]);
        wait_state(ST_IDLE);
        if (rx_bytes.size() != 0) begin
            $display("Test %s: the DUT sent %0d more bytes than expected", name, rx_bytes.size());
            other_errors++;
            rx_bytes.delete();
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    endtask

    initial capture_tx();

    initial begin
        @(posedge clock);
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        print_counts();
        $display("Regression failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        rx    = 1'b1;      // Serial line idles high
        seed  = 95;
        build_table();
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        check_flag("reset o_tx", 1'b1, tx);
        check_flag("reset o_halted", 1'b0, halted);
        check_state("reset state", ST_IDLE, state);
        send_byte(8'h5a);
        repeat (2 * FRAME_CYCLES) @(negedge clock);
        check_state("unknown command", ST_IDLE, state);
        if (rx_bytes.size() != 0) begin
            $display("The DUT transmitted bytes after an unknown command");
            other_errors++;
            rx_bytes.delete();
        end

        // Dumps straight after reset are all zero
        send_byte(CMD_SEND_PC);
        for (int i = 0; i < 4; i++)
            expect_byte($sformatf("reset pc byte %0d", i), 8'h00);
        wait_state(ST_IDLE);
        send_byte(CMD_SEND_RB);
        for (int i = 0; i < 4 * RB_DEPTH; i++)
            expect_byte($sformatf("reset rb byte %0d", i), 8'h00);
        wait_state(ST_IDLE);

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);

        print_counts();
        if (value_errors == 0 && other_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* sources.f */
verilog/debug_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/debug_unit.sv
verilog/toy_core.sv
verilog/debug_top.sv
tests/tb_clock.sv
tests/debug_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide from the log

rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module debug_tb -f sources.f -o debug_sim \
    && ./obj_dir/debug_sim | tee sim.log

grep -qs "Regression passed" sim.log \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL, see sim.log"; exit 1; }
